// File: compile.f
+incdir+src
src/riscv_isa_pkg.sv
src/int_path_pkg.sv
src/int_regfile.sv
src/pipe_stage.sv
src/int_decode.sv
src/int_alu.sv
src/int_result.sv
src/int_path_top.sv
sim/int_path_tb.sv

// File: Makefile
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module int_path_tb \
		-f compile.f --Mdir $(BUILD) -o int_path_tb
	./$(BUILD)/int_path_tb

clean:
	rm -rf $(BUILD)

// File: sim/int_path_tb.sv
`default_nettype none

`include "int_path_macros.svh"

module int_path_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import int_path_pkg::*;

    localparam logic [31:0] SEED    = 32'h23f6;
    localparam int          TIMEOUT = 200;
    localparam logic [6:0]  OPC_IMM = 7'b0010011;
    localparam logic [6:0]  OPC_REG = 7'b0110011;
    localparam logic [6:0]  OPC_LUI = 7'b0110111;

    logic        cpu_clock = 1'b0;
    logic        rst_n_i;
    logic [31:0] inst_i;
    logic        inst_valid_i;
    logic        inst_ready_o;
    int_result_t res_o;
    logic        res_valid_o;
    logic        res_ready_i;

    logic [31:0]          stim_state;
    logic [31:0]          bp_state;
    logic                 bp_random;
    logic [`INT_XLEN-1:0] model_regs [`INT_REG_COUNT] = '{default: '0};
    int_result_t          exp_q [$];
    int_result_t          cur_exp;
    int_result_t          exp_head = '0;
    logic                 exp_avail = 1'b0;
    logic                 seen_accept = 1'b0;
    int                   n_acc = 0;
    int                   n_res = 0;

    int_path_top uut (
        .cpu_clock_i  (cpu_clock),
        .rst_n_i      (rst_n_i),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .res_o        (res_o),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i)
    );

    always #20 cpu_clock = ~cpu_clock;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    function automatic string record_text(input int_result_t r);
        return $sformatf("rd=%h value=%h illegal=%h cause=%h", r.rd, r.value, r.illegal, r.cause);
    endfunction

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rnd();
        stim_state = lcg_step(stim_state);
        return stim_state;
    endfunction

    // Any register but x0 drawn from the upper LCG bits
    function automatic logic [4:0] pick_reg();
        return 5'((rnd() >> 8) % 31 + 1);
    endfunction

    // RV32I integer semantics selected by funct3 and the bit-30 alternate
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << sh;
            3'b010: return {31'd0, $signed(a) < $signed(b)};
            3'b011: return {31'd0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> sh;
                return a >> sh;
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Holds the word on the channel until the DUT takes it
    task automatic push_inst(input logic [31:0] word, input int_result_t exp);
        int waited;
        waited       = 0;
        inst_i       = word;
        inst_valid_i = 1'b1;
        cur_exp      = exp;
        @(posedge cpu_clock);
        while (!inst_ready_o) begin
            waited++;
            if (waited > TIMEOUT) abort_run("an instruction was not accepted before the timeout");
            @(posedge cpu_clock);
        end
        @(negedge cpu_clock);
        inst_valid_i = 1'b0;
    endtask

    task automatic imm_op(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
        logic [31:0] b;
        logic        alt;
        int_result_t exp;
        alt = 1'b0;
        b   = {{20{imm[11]}}, imm};
        // Shifts carry a five-bit amount and only SRAI may set bit 30
        if (f3 == 3'b001 || f3 == 3'b101) begin
            imm[11:5] = {1'b0, (f3 == 3'b101) && imm[10], 5'b0};
            alt       = imm[10];
            b         = {27'd0, imm[4:0]};
        end
        exp = '{rd: rd, value: ref_alu(f3, alt, model_regs[rs1], b), illegal: 1'b0, cause: 4'd0};
        push_inst({imm, rs1, f3, rd, OPC_IMM}, exp);
    endtask

    task automatic reg_op(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
        int_result_t exp;
        exp = '{rd: rd, value: ref_alu(f3, alt, model_regs[rs1], model_regs[rs2]),
                illegal: 1'b0, cause: 4'd0};
        push_inst({alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, OPC_REG}, exp);
    endtask

    task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
        int_result_t exp;
        exp = '{rd: rd, value: {imm, 12'b0}, illegal: 1'b0, cause: 4'd0};
        push_inst({imm, rd, OPC_LUI}, exp);
    endtask

    task automatic bad_encoding(input logic [31:0] word);
        int_result_t exp;
        exp = '{rd: '0, value: word, illegal: 1'b1, cause: 4'd2};
        push_inst(word, exp);
    endtask

    // Reference model retires first and then accepts on each edge
    always @(posedge cpu_clock) begin
        if (res_valid_o && res_ready_i && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            n_res <= n_res + 1;
        end
        if (inst_valid_i && inst_ready_o) begin
            exp_q.push_back(cur_exp);
            if (!cur_exp.illegal && cur_exp.rd != '0) model_regs[cur_exp.rd] = cur_exp.value;
            seen_accept <= 1'b1;
            n_acc       <= n_acc + 1;
        end
        exp_avail <= exp_q.size() > 0;
        exp_head  <= exp_q.size() > 0 ? exp_q[0] : '0;
    end

    idle_after_reset: assert property (@(posedge cpu_clock)
        (rst_n_i && !seen_accept) |-> !res_valid_o)
        else abort_run($sformatf("FAILED res_valid_o=%h before any instruction was accepted",
                                 $sampled(res_valid_o)));

    record_expected: assert property (@(posedge cpu_clock) disable iff (!rst_n_i)
        (res_valid_o && res_ready_i) |-> exp_avail)
        else abort_run("a result record left while no instruction was outstanding");

    record_matches: assert property (@(posedge cpu_clock) disable iff (!rst_n_i)
        (res_valid_o && res_ready_i && exp_avail) |-> (res_o == exp_head))
        else abort_run($sformatf("FAILED res_o got %s expected %s",
                                 record_text($sampled(res_o)), record_text($sampled(exp_head))));

    held_under_stall: assert property (@(posedge cpu_clock) disable iff (!rst_n_i)
        (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o)))
        else abort_run($sformatf("FAILED res_o not held under back-pressure, res_valid_o=%h %s",
                                 $sampled(res_valid_o), record_text($sampled(res_o))));

    // Result-side ready stays high until the back-pressure phase
    initial begin
        bp_state    = SEED;
        res_ready_i = 1'b0;
        forever begin
            @(negedge cpu_clock);
            if (bp_random) begin
                bp_state    = lcg_step(bp_state);
                res_ready_i = bp_state[24];
            end else begin
                res_ready_i = 1'b1;
            end
        end
    end

    initial begin
        int          i;
        int          waited;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  prev;
        logic [31:0] r;
        stim_state   = SEED;
        rst_n_i      = 1'b0;
        inst_i       = '0;
        inst_valid_i = 1'b0;
        bp_random    = 1'b0;
        repeat (8) @(negedge cpu_clock);
        rst_n_i = 1'b1;
        repeat (4) @(negedge cpu_clock);

        // LUI then ADDI on the same register stalls on its own destination
        for (i = 1; i < 32; i++) begin
            r = rnd();
            load_upper(5'(i), r[31:12]);
            imm_op(3'b000, 5'(i), 5'(i), r[11:0]);
        end

        // Every OP-IMM selector where bit 18 of r turns some SRLI into SRAI
        for (i = 0; i < 48; i++) begin
            r = rnd();
            imm_op(3'(i % 8), pick_reg(), pick_reg(), r[19:8]);
        end

        // Each OP reads the previous destination
        prev = pick_reg();
        for (i = 0; i < 40; i++) begin
            r  = rnd();
            f3 = r[10:8];
            rd = pick_reg();
            reg_op(f3, r[12] && (f3 == 3'b000 || f3 == 3'b101), rd, prev, pick_reg());
            prev = rd;
        end

        r = rnd();
        imm_op(3'b000, 5'd0, pick_reg(), r[11:0]);
        reg_op(3'b110, 1'b0, pick_reg(), 5'd0, 5'd0);
        reg_op(3'b000, 1'b0, pick_reg(), 5'd0, pick_reg());

        // LW, AND with the SUB funct7, SLLI with bit 30 and an all-zero word
        rd = pick_reg();
        bad_encoding({12'h010, 5'd3, 3'b010, rd, 7'b0000011});
        bad_encoding({7'b0100000, 5'd4, 5'd5, 3'b111, rd, OPC_REG});
        bad_encoding({7'b0100000, 5'd2, 5'd6, 3'b001, rd, OPC_IMM});
        bad_encoding(32'h0);
        reg_op(3'b110, 1'b0, pick_reg(), rd, 5'd0);

        bp_random = 1'b1;
        prev      = pick_reg();
        for (i = 0; i < 150; i++) begin
            r  = rnd();
            rd = pick_reg();
            f3 = r[10:8];
            case (r[14:13])
                2'd0: imm_op(f3, rd, prev, r[27:16]);
                2'd1: reg_op(f3, r[12] && (f3 == 3'b000 || f3 == 3'b101), rd, prev, pick_reg());
                2'd2: load_upper(rd, r[31:12]);
                default: bad_encoding({r[31:7], 7'b0000011});
            endcase
            prev = rd;
            if (r[15]) @(negedge cpu_clock);
        end

        waited = 0;
        while (n_res != n_acc) begin
            waited++;
            if (waited > TIMEOUT) abort_run("the result records did not drain before the timeout");
            @(negedge cpu_clock);
        end
        repeat (4) @(negedge cpu_clock);

        // All records have left, so nothing may be offered any more
        if (res_valid_o) begin
            abort_run($sformatf("FAILED res_valid_o=%h with no instruction outstanding",
                                res_valid_o));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src/int_path_top.sv
`default_nettype none

`include "int_path_macros.svh"

module int_path_top (
    input  wire logic                 cpu_clock_i,
    input  wire logic                 rst_n_i,
    input  wire logic [31:0]          inst_i,
    input  wire logic                 inst_valid_i,
    output logic                      inst_ready_o,
    output int_path_pkg::int_result_t res_o,
    output logic                      res_valid_o,
    input  wire logic                 res_ready_i
);

    import int_path_pkg::*;

    logic [`INT_REG_BITS-1:0] rs1_addr;
    logic [`INT_REG_BITS-1:0] rs2_addr;
    logic [`INT_XLEN-1:0]     rs1_data;
    logic [`INT_XLEN-1:0]     rs2_data;

    int_uop_t  uop_d;
    logic      uop_d_valid;
    logic      uop_d_ready;
    int_uop_t  uop_q;
    logic      uop_q_valid;
    logic      uop_q_ready;
    int_exec_t exec_d;
    logic      exec_d_valid;
    logic      exec_d_ready;
    int_exec_t exec_q;
    logic      exec_q_valid;
    logic      exec_q_ready;

    logic                     wb_en;
    logic [`INT_REG_BITS-1:0] wb_rd;
    logic [`INT_XLEN-1:0]     wb_data;

    int_decode u_decode (
        .cpu_clock_i  (cpu_clock_i),
        .rst_n_i      (rst_n_i),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .uop_o        (uop_d),
        .uop_valid_o  (uop_d_valid),
        .uop_ready_i  (uop_d_ready),
        .wb_en_i      (wb_en),
        .wb_rd_i      (wb_rd)
    );

    int_regfile u_regfile (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .rs1_addr_i  (rs1_addr),
        .rs2_addr_i  (rs2_addr),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .we_i        (wb_en),
        .wr_addr_i   (wb_rd),
        .wr_data_i   (wb_data)
    );

    pipe_stage #(.payload_t(int_uop_t)) u_uop_stage (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .in_i        (uop_d),
        .in_valid_i  (uop_d_valid),
        .in_ready_o  (uop_d_ready),
        .out_o       (uop_q),
        .out_valid_o (uop_q_valid),
        .out_ready_i (uop_q_ready)
    );

    int_alu u_alu (
        .uop_i        (uop_q),
        .uop_valid_i  (uop_q_valid),
        .uop_ready_o  (uop_q_ready),
        .exec_o       (exec_d),
        .exec_valid_o (exec_d_valid),
        .exec_ready_i (exec_d_ready)
    );

    pipe_stage #(.payload_t(int_exec_t)) u_exec_stage (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .in_i        (exec_d),
        .in_valid_i  (exec_d_valid),
        .in_ready_o  (exec_d_ready),
        .out_o       (exec_q),
        .out_valid_o (exec_q_valid),
        .out_ready_i (exec_q_ready)
    );

    int_result u_result (
        .cpu_clock_i  (cpu_clock_i),
        .rst_n_i      (rst_n_i),
        .exec_i       (exec_q),
        .exec_valid_i (exec_q_valid),
        .exec_ready_o (exec_q_ready),
        .res_o        (res_o),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i),
        .wb_en_o      (wb_en),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data)
    );

endmodule

`default_nettype wire

// File: src/int_result.sv
`default_nettype none

`include "int_path_macros.svh"

module int_result (
    input  wire logic                    cpu_clock_i,
    input  wire logic                    rst_n_i,
    input  wire int_path_pkg::int_exec_t exec_i,
    input  wire logic                    exec_valid_i,
    output logic                         exec_ready_o,
    output int_path_pkg::int_result_t    res_o,
    output logic                         res_valid_o,
    input  wire logic                    res_ready_i,
    output logic                         wb_en_o,
    output logic [`INT_REG_BITS-1:0]     wb_rd_o,
    output logic [`INT_XLEN-1:0]         wb_data_o
);

    import riscv_isa_pkg::*;
    import int_path_pkg::*;

    logic        valid_q;
    int_result_t rec_q;
    int_result_t rec_d;
    logic        load;

    always_comb begin
        rec_d.rd      = exec_i.illegal ? '0 : exec_i.rd;
        rec_d.value   = exec_i.value;
        rec_d.illegal = exec_i.illegal;
        rec_d.cause   = exec_i.illegal ? CAUSE_ILLEGAL_INSTR : 4'd0;
    end

    assign exec_ready_o = !valid_q || res_ready_i;
    assign load         = exec_valid_i && exec_ready_o;

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (res_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (load) begin
            rec_q <= rec_d;
        end
    end

    assign res_o       = rec_q;
    assign res_valid_o = valid_q;

    // The register file and scoreboard see the write on the transfer edge
    assign wb_en_o   = valid_q && res_ready_i && !rec_q.illegal && (rec_q.rd != '0);
    assign wb_rd_o   = rec_q.rd;
    assign wb_data_o = rec_q.value;

endmodule

`default_nettype wire

// File: src/int_alu.sv
`default_nettype none

`include "int_path_macros.svh"

module int_alu (
    input  wire int_path_pkg::int_uop_t uop_i,
    input  wire logic                   uop_valid_i,
    output logic                        uop_ready_o,
    output int_path_pkg::int_exec_t     exec_o,
    output logic                        exec_valid_o,
    input  wire logic                   exec_ready_i
);

    import int_path_pkg::*;

    logic [`INT_XLEN-1:0] a;
    logic [`INT_XLEN-1:0] b;
    logic [`INT_XLEN-1:0] value;
    logic [4:0]           sh;
    logic                 lt_s;
    logic                 lt_u;

    assign a    = uop_i.op_a;
    assign b    = uop_i.op_b;
    assign sh   = b[4:0];
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (uop_i.alu_op)
            ALU_ADD:    value = a + b;
            ALU_SUB:    value = a - b;
            ALU_SLL:    value = a << sh;
            ALU_SLT:    value = {{(`INT_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   value = {{(`INT_XLEN-1){1'b0}}, lt_u};
            ALU_XOR:    value = a ^ b;
            ALU_SRL:    value = a >> sh;
            ALU_SRA:    value = $signed(a) >>> sh;
            ALU_OR:     value = a | b;
            ALU_AND:    value = a & b;
            ALU_PASS_B: value = b;
            default:    value = '0;
        endcase
        // Illegal ops report the instruction word held in operand A
        if (uop_i.illegal) begin
            value = a;
        end
    end

    assign exec_o = '{
        rd:      uop_i.rd,
        value:   value,
        illegal: uop_i.illegal
    };

    // No state here, the handshake passes straight through
    assign exec_valid_o = uop_valid_i;
    assign uop_ready_o  = exec_ready_i;

endmodule

`default_nettype wire

// File: src/int_decode.sv
`default_nettype none

`include "int_path_macros.svh"

module int_decode (
    input  wire logic                     cpu_clock_i,
    input  wire logic                     rst_n_i,
    input  wire logic [31:0]              inst_i,
    input  wire logic                     inst_valid_i,
    output logic                          inst_ready_o,
    output logic      [`INT_REG_BITS-1:0] rs1_addr_o,
    output logic      [`INT_REG_BITS-1:0] rs2_addr_o,
    input  wire logic [`INT_XLEN-1:0]     rs1_data_i,
    input  wire logic [`INT_XLEN-1:0]     rs2_data_i,
    output int_path_pkg::int_uop_t        uop_o,
    output logic                          uop_valid_o,
    input  wire logic                     uop_ready_i,
    input  wire logic                     wb_en_i,
    input  wire logic [`INT_REG_BITS-1:0] wb_rd_i
);

    import riscv_isa_pkg::*;
    import int_path_pkg::*;

    // Where operand B comes from
    typedef enum logic [1:0] {
        B_REG,
        B_IMM,
        B_SHAMT,
        B_UIMM
    } b_sel_e;

    opcode_e                  opcode;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    logic [`INT_REG_BITS-1:0] rd;
    logic [`INT_REG_BITS-1:0] rs1;
    logic [`INT_REG_BITS-1:0] rs2;
    logic [`INT_XLEN-1:0]     imm_i;
    logic [`INT_XLEN-1:0]     imm_u;
    logic [`INT_XLEN-1:0]     shamt;
    logic [`INT_XLEN-1:0]     op_a;
    logic [`INT_XLEN-1:0]     op_b;
    alu_op_e                  alu_op;
    b_sel_e                   b_sel;
    logic                     legal;
    logic                     use_rs1;
    logic                     use_rs2;
    logic                     alt;
    logic                     stall;
    logic                     accept;
    logic [`INT_REG_COUNT-1:0] busy_q;

    assign opcode = opcode_e'(inst_i[OPCODE_LSB +: 7]);
    assign rd     = inst_i[RD_LSB +: `INT_REG_BITS];
    assign funct3 = inst_i[FUNCT3_LSB +: 3];
    assign rs1    = inst_i[RS1_LSB +: `INT_REG_BITS];
    assign rs2    = inst_i[RS2_LSB +: `INT_REG_BITS];
    assign funct7 = inst_i[FUNCT7_LSB +: 7];
    assign alt    = (funct7 == F7_ALT);

    assign imm_i = {{(`INT_XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign shamt = {{(`INT_XLEN-5){1'b0}}, inst_i[RS2_LSB +: 5]};

    always_comb begin
        alu_op  = ALU_ADD;
        b_sel   = B_REG;
        legal   = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OP_IMM: begin
                use_rs1 = 1'b1;
                b_sel   = B_IMM;
                legal   = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_op = ALU_ADD;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    F3_SLL: begin
                        alu_op = ALU_SLL;
                        b_sel  = B_SHAMT;
                        legal  = (funct7 == F7_BASE);
                    end
                    F3_SRL_SRA: begin
                        alu_op = alt ? ALU_SRA : ALU_SRL;
                        b_sel  = B_SHAMT;
                        legal  = (funct7 == F7_BASE) || alt;
                    end
                endcase
            end
            OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                // Only ADD and SRL have an alternate form
                legal   = (funct7 == F7_BASE) ||
                          (alt && ((funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA)));
                case (funct3)
                    F3_ADD_SUB: alu_op = alt ? ALU_SUB : ALU_ADD;
                    F3_SLL:     alu_op = ALU_SLL;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SRL_SRA: alu_op = alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                endcase
            end
            LUI: begin
                alu_op = ALU_PASS_B;
                b_sel  = B_UIMM;
                legal  = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
        end
    end

    // Unused ports are parked on x0
    assign rs1_addr_o = use_rs1 ? rs1 : '0;
    assign rs2_addr_o = use_rs2 ? rs2 : '0;

    always_comb begin
        case (b_sel)
            B_REG:   op_b = rs2_data_i;
            B_IMM:   op_b = imm_i;
            B_SHAMT: op_b = shamt;
            default: op_b = imm_u;
        endcase
    end

    assign op_a = use_rs1 ? rs1_data_i : (legal ? '0 : inst_i);

    assign uop_o = '{
        alu_op:  alu_op,
        rd:      legal ? rd : '0,
        op_a:    op_a,
        op_b:    legal ? op_b : '0,
        illegal: !legal
    };

    // A busy destination also stalls, so each busy bit has one producer
    // and an older writeback cannot release a newer claim
    assign stall = (use_rs1 && busy_q[rs1]) ||
                   (use_rs2 && busy_q[rs2]) ||
                   (legal && busy_q[rd]);

    assign uop_valid_o  = inst_valid_i && !stall;
    assign inst_ready_o = uop_ready_i && !stall;
    assign accept       = inst_valid_i && inst_ready_o;

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            if (wb_en_i) begin
                busy_q[wb_rd_i] <= 1'b0;
            end
            if (accept && legal && (rd != '0)) begin
                busy_q[rd] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pipe_stage.sv
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  wire logic     cpu_clock_i,
    input  wire logic     rst_n_i,
    input  wire payload_t in_i,
    input  wire logic     in_valid_i,
    output logic          in_ready_o,
    output payload_t      out_o,
    output logic          out_valid_o,
    input  wire logic     out_ready_i
);

    logic     valid_q;
    payload_t data_q;
    logic     load;

    // Room exists when empty or when the held entry leaves this cycle
    assign in_ready_o = !valid_q || out_ready_i;
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (load) begin
            data_q <= in_i;
        end
    end

    assign out_o       = data_q;
    assign out_valid_o = valid_q;

endmodule

`default_nettype wire

// File: src/int_regfile.sv
`default_nettype none

`include "int_path_macros.svh"

module int_regfile (
    input  wire logic                     cpu_clock_i,
    input  wire logic                     rst_n_i,
    input  wire logic [`INT_REG_BITS-1:0] rs1_addr_i,
    input  wire logic [`INT_REG_BITS-1:0] rs2_addr_i,
    output logic      [`INT_XLEN-1:0]     rs1_data_o,
    output logic      [`INT_XLEN-1:0]     rs2_data_o,
    input  wire logic                     we_i,
    input  wire logic [`INT_REG_BITS-1:0] wr_addr_i,
    input  wire logic [`INT_XLEN-1:0]     wr_data_i
);

    // x0 has no storage, entry 0 is never built
    logic [`INT_XLEN-1:0] regs [1:`INT_REG_COUNT-1];

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `INT_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

// File: src/int_path_pkg.sv
`default_nettype none

`include "int_path_macros.svh"

package int_path_pkg;

    // Operations the execute stage knows, PASS_B serves LUI
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // Decoded instruction with its operands already read
    // An illegal op keeps the raw instruction word in op_a
    typedef struct packed {
        alu_op_e                  alu_op;
        logic [`INT_REG_BITS-1:0] rd;
        logic [`INT_XLEN-1:0]     op_a;
        logic [`INT_XLEN-1:0]     op_b;
        logic                     illegal;
    } int_uop_t;

    // Output of the execute stage
    typedef struct packed {
        logic [`INT_REG_BITS-1:0] rd;
        logic [`INT_XLEN-1:0]     value;
        logic                     illegal;
    } int_exec_t;

    // Record reported for every retired instruction
    typedef struct packed {
        logic [`INT_REG_BITS-1:0] rd;
        logic [`INT_XLEN-1:0]     value;
        logic                     illegal;
        logic [3:0]               cause;
    } int_result_t;

endpackage

`default_nettype wire

// File: src/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

    // Major opcodes handled by the integer lane
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111
    } opcode_e;

    // Low bit of each instruction field
    localparam int unsigned OPCODE_LSB = 0;
    localparam int unsigned RD_LSB     = 7;
    localparam int unsigned FUNCT3_LSB = 12;
    localparam int unsigned RS1_LSB    = 15;
    localparam int unsigned RS2_LSB    = 20;
    localparam int unsigned FUNCT7_LSB = 25;

    // ALU selector in funct3, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 is zero for the base form and has bit 30 set for SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // Machine exception cause for an instruction the lane cannot execute
    localparam logic [3:0] CAUSE_ILLEGAL_INSTR = 4'd2;

endpackage

`default_nettype wire

// File: src/int_path_macros.svh
`ifndef INT_PATH_MACROS_SVH
`define INT_PATH_MACROS_SVH

// Width of one integer register and of the ALU datapath
`define INT_XLEN 32

// Architectural registers, x0 included
`define INT_REG_COUNT 32

// Bits needed to name one architectural register
`define INT_REG_BITS 5

`endif
